/* rv_alu_core.f */
logic/rv_isa_pkg.sv
logic/core_pkg.sv
logic/regfile.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/rv_core.sv
verif/rv_core_assert.sv
verif/rv_core_tb.sv

/* Makefile */
# Verilator flow for the RV32I execution core

VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILELIST  ?= rv_alu_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= All tests passed
VFLAGS    ?= --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# The log decides the result, whatever the binary returns
sim: $(SIM_BIN)
	-./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)
	@echo "Simulation log check passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verif/rv_core_tb.sv */
`default_nettype none
`timescale 1ns/1ps

module rv_core_tb
    import rv_isa_pkg::*;
    import core_pkg::*;
();

    localparam real DRIVE_DELAY = 0.5;
    localparam int  N_RANDOM    = 400;
    localparam int  MAX_GAP     = 3;
    // Upper bound on issue slots taken by the directed tests
    localparam int  DIRECTED_SLOTS = 250;
    localparam int  CYCLE_LIMIT = 2 + DIRECTED_SLOTS + N_RANDOM * (MAX_GAP + 1)
                                  + CORE_LATENCY + 50;

    typedef struct packed {
        reg_idx_t        rd;
        logic [XLEN-1:0] data;
    } exp_write_t;

    logic            clk = 1'b0;
    logic            reset;
    issue_t          issue;
    wb_t             wb;
    logic [XLEN-1:0] shadow [0:31];
    exp_write_t      expected [$];
    int              cycle_count = 0;

    rv_core i_rv_core (
        .clk   (clk),
        .reset (reset),
        .issue (issue),
        .wb    (wb)
    );

    always #2 clk = ~clk;

    task automatic abort_run(string reason);
        $display("%s", reason);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_value(string what, logic [XLEN-1:0] got, logic [XLEN-1:0] want);
        if (got !== want) begin
            abort_run($sformatf("[FAIL] %0.1f ns: %s is %h, expected %h",
                                $realtime, what, got, want));
        end
    endtask

    function automatic logic [31:0] op_word(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                            logic [2:0] f3, reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] op_imm_word(logic [11:0] imm, reg_idx_t rs1,
                                                logic [2:0] f3, reg_idx_t rd);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] lui_word(logic [19:0] imm, reg_idx_t rd);
        return {imm, rd, OPC_LUI};
    endfunction

    // Opcode and function combinations the core executes
    function automatic logic supported(logic [31:0] word);
        logic [2:0] f3;
        logic [6:0] f7;
        logic       ok;
        f3 = word[14:12];
        f7 = word[31:25];
        case (word[6:0])
            OPC_OP: begin
                ok = f7 == F7_BASE ||
                     (f7 == F7_ALT && (f3 == F3_ADD_SUB || f3 == F3_SRL_SRA));
            end
            OPC_OP_IMM: begin
                if (f3 == F3_SLL) begin
                    ok = f7 == F7_BASE;
                end else if (f3 == F3_SRL_SRA) begin
                    ok = f7 == F7_BASE || f7 == F7_ALT;
                end else begin
                    ok = 1'b1;
                end
            end
            OPC_LUI: begin
                ok = 1'b1;
            end
            default: begin
                ok = 1'b0;
            end
        endcase
        return ok;
    endfunction

    function automatic logic [XLEN-1:0] reference_result(logic [31:0] word, logic [XLEN-1:0] a,
                                                         logic [XLEN-1:0] rs2_val);
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] res;
        logic            alt;
        alt = word[30];
        b   = (word[6:0] == OPC_OP) ? rs2_val : {{20{word[31]}}, word[31:20]};
        case (word[14:12])
            3'b000:  res = (word[6:0] == OPC_OP && alt) ? a - b : a + b;
            3'b001:  res = a << b[4:0];
            3'b010:  res = {31'b0, $signed(a) < $signed(b)};
            3'b011:  res = {31'b0, a < b};
            3'b100:  res = a ^ b;
            3'b101:  res = alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  res = a | b;
            default: res = a & b;
        endcase
        if (word[6:0] == OPC_LUI) begin
            res = {word[31:12], 12'b0};
        end
        return res;
    endfunction

    // Drives one issue slot and records the write it must produce
    task automatic issue_inst(logic [31:0] word);
        reg_idx_t   rd;
        exp_write_t w;
        rd          = word[11:7];
        issue.valid = 1'b1;
        issue.inst  = word;
        if (supported(word) && rd != '0) begin
            w.rd      = rd;
            w.data    = reference_result(word, shadow[word[19:15]], shadow[word[24:20]]);
            shadow[rd] = w.data;
            expected.push_back(w);
        end
        @(posedge clk);
        #DRIVE_DELAY;
        issue.valid = 1'b0;
    endtask

    task automatic wait_cycles(int n);
        repeat (n) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
    endtask

    task automatic load_const(reg_idx_t rd, logic [XLEN-1:0] value);
        logic [XLEN-1:0] upper;
        upper = value + 32'h800;
        issue_inst(lui_word(upper[31:12], rd));
        issue_inst(op_imm_word(value[11:0], rd, F3_ADD_SUB, rd));
    endtask

    // Every ALU operation on x1 and x2, register and immediate forms
    task automatic run_alu_ops(logic [XLEN-1:0] a_val, logic [XLEN-1:0] b_val,
                               logic [11:0] imm, logic [4:0] shamt);
        logic [2:0] f3;
        load_const(5'd1, a_val);
        load_const(5'd2, b_val);
        for (int f = 0; f < 8; f++) begin
            f3 = 3'(f);
            issue_inst(op_word(F7_BASE, 5'd2, 5'd1, f3, 5'd3));
            if (f3 == F3_SLL || f3 == F3_SRL_SRA) begin
                issue_inst(op_imm_word({F7_BASE, shamt}, 5'd1, f3, 5'd4));
            end else begin
                issue_inst(op_imm_word(imm, 5'd1, f3, 5'd4));
            end
        end
        issue_inst(op_word(F7_ALT, 5'd2, 5'd1, F3_ADD_SUB, 5'd5));
        issue_inst(op_word(F7_ALT, 5'd2, 5'd1, F3_SRL_SRA, 5'd5));
        issue_inst(op_imm_word({F7_ALT, shamt}, 5'd1, F3_SRL_SRA, 5'd6));
    endtask

    function automatic logic [31:0] random_word();
        logic [31:0] word;
        logic [31:0] r;
        logic [4:0]  mask;
        logic [6:0]  alt_f7;
        word = $urandom;
        r    = $urandom;
        // Mostly low registers so dependencies are frequent
        mask         = r[3] ? 5'h1f : 5'h07;
        word[11:7]   = word[11:7] & mask;
        word[19:15]  = word[19:15] & mask;
        word[24:20]  = word[24:20] & mask;
        alt_f7       = r[6] ? F7_ALT : F7_BASE;
        case (r[5:4])
            2'd0: begin
                word[6:0]   = OPC_OP;
                word[31:25] = (word[14:12] == F3_ADD_SUB || word[14:12] == F3_SRL_SRA) ?
                              alt_f7 : F7_BASE;
            end
            2'd1: begin
                word[6:0] = OPC_OP_IMM;
                if (word[14:12] == F3_SLL) begin
                    word[31:25] = F7_BASE;
                end else if (word[14:12] == F3_SRL_SRA) begin
                    word[31:25] = alt_f7;
                end
            end
            2'd2: begin
                word[6:0] = OPC_LUI;
            end
            default: begin
                // Load or branch opcode, else the raw random word
                if (!r[6]) begin
                    word[6:0] = r[7] ? 7'b0000011 : 7'b1100011;
                end
            end
        endcase
        return word;
    endfunction

    always @(negedge clk) begin
        exp_write_t w;
        if (!reset && wb.valid) begin
            if (expected.size() == 0) begin
                abort_run("Write-back seen while no register write was expected");
            end else begin
                w = expected.pop_front();
                check_value("wb.rd", {27'b0, wb.rd}, {27'b0, w.rd});
                check_value("wb.data", wb.data, w.data);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            abort_run($sformatf("Timeout: run still going after %0d cycles", CYCLE_LIMIT));
        end
    end

    initial begin
        int gap;
        void'($urandom(32'hdb36934f));
        reset = 1'b1;
        issue = '0;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;

        // Each register read before any write
        for (int r = 1; r < 32; r++) begin
            issue_inst(op_word(F7_BASE, 5'(r), 5'(r), F3_ADD_SUB, 5'(r)));
        end
        issue_inst(op_imm_word(12'h7ff, 5'd0, F3_ADD_SUB, 5'd1));
        issue_inst(op_imm_word(12'h800, 5'd0, F3_ADD_SUB, 5'd2));
        issue_inst(op_imm_word(12'hfff, 5'd0, F3_ADD_SUB, 5'd3));
        issue_inst(op_imm_word(12'h001, 5'd0, F3_ADD_SUB, 5'd4));
        issue_inst(op_imm_word(12'ha5a, 5'd0, F3_ADD_SUB, 5'd5));

        run_alu_ops(32'hffffff80, 32'h00000005, 12'hffd, 5'd4);
        run_alu_ops(32'h7ffffff0, 32'h80000001, 12'h801, 5'd31);
        run_alu_ops(32'h80000000, 32'hfffffff0, 12'h800, 5'd1);
        run_alu_ops(32'h12345678, 32'h12345678, 12'h678, 5'd0);
        issue_inst(lui_word(20'hfffff, 5'd7));
        issue_inst(lui_word(20'h00001, 5'd8));

        // Dependency chain at distances one and two
        issue_inst(op_imm_word(12'd1, 5'd0, F3_ADD_SUB, 5'd10));
        issue_inst(op_imm_word(12'd2, 5'd10, F3_ADD_SUB, 5'd11));
        issue_inst(op_word(F7_BASE, 5'd11, 5'd10, F3_ADD_SUB, 5'd12));
        issue_inst(op_word(F7_ALT, 5'd10, 5'd12, F3_ADD_SUB, 5'd10));
        repeat (8) issue_inst(op_word(F7_BASE, 5'd10, 5'd10, F3_ADD_SUB, 5'd10));
        issue_inst(op_word(F7_BASE, 5'd11, 5'd10, F3_XOR, 5'd13));

        // Writes to x0, then reads of x0 right behind them
        issue_inst(op_imm_word(12'h123, 5'd0, F3_ADD_SUB, 5'd0));
        issue_inst(op_word(F7_BASE, 5'd13, 5'd12, F3_ADD_SUB, 5'd0));
        issue_inst(op_word(F7_BASE, 5'd0, 5'd0, F3_OR, 5'd14));
        issue_inst(op_imm_word(12'h000, 5'd0, F3_OR, 5'd15));

        // Unsupported words followed by readers of their rd
        issue_inst({12'h004, 5'd1, 3'b010, 5'd16, 7'b0000011});
        issue_inst(op_word(F7_BASE, 5'd16, 5'd16, F3_ADD_SUB, 5'd17));
        issue_inst({7'b0000001, 5'd2, 5'd1, 3'b000, 5'd18, OPC_OP});
        issue_inst(op_word(F7_BASE, 5'd18, 5'd18, F3_OR, 5'd19));
        issue_inst(32'h00000073);
        issue_inst({20'h12345, 5'd20, 7'b0010111});
        issue_inst(op_imm_word(12'd0, 5'd20, F3_ADD_SUB, 5'd21));
        wait_cycles(3);

        repeat (N_RANDOM) begin
            issue_inst(random_word());
            gap = ($urandom_range(0, 1) == 0) ? 0 : $urandom_range(1, MAX_GAP);
            wait_cycles(gap);
        end

        wait_cycles(CORE_LATENCY + 4);
        if (expected.size() != 0) begin
            abort_run($sformatf("%0d expected register writes never came out",
                                expected.size()));
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* verif/rv_core_assert.sv */
`default_nettype none
`timescale 1ns/1ps

module rv_core_assert
    import rv_isa_pkg::*;
    import core_pkg::*;
(
    input logic   clk,
    input logic   reset,
    input issue_t issue,
    input wb_t    wb
);

    // No write-back straight out of reset
    wb_idle_after_reset: assert property (
        @(posedge clk) reset |=> !wb.valid
    ) else $error("wb.valid high in the cycle after reset");

    wb_follows_issue: assert property (
        @(posedge clk) disable iff (reset)
        wb.valid |-> $past(issue.valid, CORE_LATENCY)
    ) else $error("wb.valid without an issue CORE_LATENCY edges earlier");

    // x0 is never written
    wb_rd_nonzero: assert property (
        @(posedge clk) disable iff (reset)
        wb.valid |-> wb.rd != '0
    ) else $error("write-back to x0");

endmodule

bind rv_core rv_core_assert i_rv_core_assert (
    .clk   (clk),
    .reset (reset),
    .issue (issue),
    .wb    (wb)
);

`default_nettype wire

/* logic/rv_core.sv */
`default_nettype none
`timescale 1ns/1ps

module rv_core
    import rv_isa_pkg::*;
    import core_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  issue_t issue,
    output wb_t    wb
);

    reg_idx_t        rs1;
    reg_idx_t        rs2;
    logic [XLEN-1:0] rdata1;
    logic [XLEN-1:0] rdata2;
    exec_t           ex;

    decode_stage i_decode_stage (
        .clk    (clk),
        .reset  (reset),
        .issue  (issue),
        .rs1    (rs1),
        .rs2    (rs2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .ex     (ex)
    );

    // Write port is fed straight from the write-back register
    regfile i_regfile (
        .clk    (clk),
        .reset  (reset),
        .rs1    (rs1),
        .rs2    (rs2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .wb     (wb)
    );

    execute_stage i_execute_stage (
        .clk    (clk),
        .reset  (reset),
        .ex     (ex),
        .wb     (wb)
    );

endmodule

`default_nettype wire

/* logic/execute_stage.sv */
`default_nettype none
`timescale 1ns/1ps

module execute_stage
    import rv_isa_pkg::*;
    import core_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  exec_t ex,
    output wb_t   wb
);

    logic [XLEN-1:0] src_a;
    logic [XLEN-1:0] src_b;
    logic [XLEN-1:0] alu_b;
    logic [4:0]      shamt;
    logic [XLEN-1:0] result;

    // Result of the instruction just ahead is still in the write-back register
    function automatic logic [XLEN-1:0] forward(reg_idx_t idx,
                                                logic [XLEN-1:0] captured,
                                                wb_t wb_q);
        logic [XLEN-1:0] value;
        if (wb_q.valid && wb_q.rd == idx) begin
            value = wb_q.data;
        end else begin
            value = captured;
        end
        return value;
    endfunction

    always_comb begin
        src_a = forward(ex.rs1, ex.op_a, wb);
        src_b = forward(ex.rs2, ex.op_b, wb);
        alu_b = ex.use_imm ? ex.imm : src_b;
    end

    assign shamt = alu_b[4:0];

    always_comb begin
        case (ex.alu_op)
            ALU_ADD: begin
                result = src_a + alu_b;
            end
            ALU_SUB: begin
                result = src_a - alu_b;
            end
            ALU_SLL: begin
                result = src_a << shamt;
            end
            ALU_SLT: begin
                result = {{(XLEN - 1){1'b0}}, $signed(src_a) < $signed(alu_b)};
            end
            ALU_SLTU: begin
                result = {{(XLEN - 1){1'b0}}, src_a < alu_b};
            end
            ALU_XOR: begin
                result = src_a ^ alu_b;
            end
            ALU_SRL: begin
                result = src_a >> shamt;
            end
            ALU_SRA: begin
                result = $unsigned($signed(src_a) >>> shamt);
            end
            ALU_OR: begin
                result = src_a | alu_b;
            end
            ALU_AND: begin
                result = src_a & alu_b;
            end
            ALU_PASS_B: begin
                result = alu_b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // Write-back register
    always_ff @(posedge clk) begin
        wb.rd   <= ex.rd;
        wb.data <= result;
        if (reset) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= ex.valid && ex.we;
        end
    end

endmodule

`default_nettype wire

/* logic/decode_stage.sv */
`default_nettype none
`timescale 1ns/1ps

module decode_stage
    import rv_isa_pkg::*;
    import core_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  issue_t          issue,
    output reg_idx_t        rs1,
    output reg_idx_t        rs2,
    input  logic [XLEN-1:0] rdata1,
    input  logic [XLEN-1:0] rdata2,
    output exec_t           ex
);

    logic            inst_valid;
    rv_inst_u        inst;
    logic            legal;
    logic            use_imm;
    logic [XLEN-1:0] imm;
    alu_op_e         alu_op;
    exec_t           ex_next;

    function automatic alu_op_e funct_to_alu(logic [2:0] funct3, logic alt);
        alu_op_e op;
        case (funct3)
            F3_ADD_SUB: op = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     op = ALU_SLL;
            F3_SLT:     op = ALU_SLT;
            F3_SLTU:    op = ALU_SLTU;
            F3_XOR:     op = ALU_XOR;
            F3_SRL_SRA: op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:      op = ALU_OR;
            default:    op = ALU_AND;
        endcase
        return op;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            inst_valid <= 1'b0;
        end else begin
            inst_valid <= issue.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue.valid) begin
            inst <= issue.inst;
        end
    end

    assign rs1 = inst.r.rs1;
    assign rs2 = inst.r.rs2;

    always_comb begin
        legal   = 1'b0;
        use_imm = 1'b0;
        imm     = '0;
        alu_op  = ALU_ADD;
        case (inst.r.opcode)
            OPC_OP: begin
                legal  = (inst.r.funct7 == F7_BASE) ||
                         ((inst.r.funct7 == F7_ALT) &&
                          (inst.r.funct3 == F3_ADD_SUB || inst.r.funct3 == F3_SRL_SRA));
                alu_op = funct_to_alu(inst.r.funct3, inst.r.funct7 == F7_ALT);
            end
            OPC_OP_IMM: begin
                use_imm = 1'b1;
                imm     = {{(XLEN - 12){inst.i.imm[11]}}, inst.i.imm};
                // Shift immediates keep funct7 in the top bits
                case (inst.i.funct3)
                    F3_SLL:     legal = inst.r.funct7 == F7_BASE;
                    F3_SRL_SRA: legal = inst.r.funct7 == F7_BASE || inst.r.funct7 == F7_ALT;
                    default:    legal = 1'b1;
                endcase
                alu_op = funct_to_alu(inst.i.funct3,
                                      inst.i.funct3 == F3_SRL_SRA && inst.r.funct7 == F7_ALT);
            end
            OPC_LUI: begin
                legal   = 1'b1;
                use_imm = 1'b1;
                imm     = {inst.i.imm, inst.i.rs1, inst.i.funct3, 12'b0};
                alu_op  = ALU_PASS_B;
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

    always_comb begin
        ex_next.valid   = inst_valid && legal;
        ex_next.we      = inst.r.rd != '0;
        ex_next.rd      = inst.r.rd;
        ex_next.rs1     = inst.r.rs1;
        ex_next.rs2     = inst.r.rs2;
        ex_next.op_a    = rdata1;
        ex_next.op_b    = rdata2;
        ex_next.use_imm = use_imm;
        ex_next.imm     = imm;
        ex_next.alu_op  = alu_op;
    end

    always_ff @(posedge clk) begin
        ex <= ex_next;
        if (reset) begin
            ex.valid <= 1'b0;
            ex.we    <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* logic/regfile.sv */
`default_nettype none
`timescale 1ns/1ps

module regfile
    import rv_isa_pkg::*;
    import core_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  reg_idx_t        rs1,
    input  reg_idx_t        rs2,
    output logic [XLEN-1:0] rdata1,
    output logic [XLEN-1:0] rdata2,
    input  wb_t             wb
);

    logic [XLEN-1:0] regs [1:31];

    // x0 reads zero, a write in flight is seen at once
    function automatic logic [XLEN-1:0] read_reg(reg_idx_t idx);
        logic [XLEN-1:0] value;
        if (idx == '0) begin
            value = '0;
        end else if (wb.valid && wb.rd == idx) begin
            value = wb.data;
        end else begin
            value = regs[idx];
        end
        return value;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid) begin
            regs[wb.rd] <= wb.data;
        end
    end

    always_comb begin
        rdata1 = read_reg(rs1);
        rdata2 = read_reg(rs2);
    end

endmodule

`default_nettype wire

/* logic/core_pkg.sv */
`default_nettype none

package core_pkg;

    import rv_isa_pkg::*;

    // Clock edges from issue to write-back
    localparam int CORE_LATENCY = 3;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    typedef struct packed {
        logic     valid;
        rv_inst_u inst;
    } issue_t;

    typedef struct packed {
        logic            valid;
        logic            we;
        reg_idx_t        rd;
        reg_idx_t        rs1;
        reg_idx_t        rs2;
        logic [XLEN-1:0] op_a;
        logic [XLEN-1:0] op_b;
        logic            use_imm;
        logic [XLEN-1:0] imm;
        alu_op_e         alu_op;
    } exec_t;

    typedef struct packed {
        logic            valid;
        reg_idx_t        rd;
        logic [XLEN-1:0] data;
    } wb_t;

endpackage

`default_nettype wire

/* logic/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    localparam int XLEN = 32;

    typedef logic [4:0] reg_idx_t;

    // Major opcodes handled by the core
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Alternate funct7 selects SUB and SRA
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } rv_r_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } rv_i_t;

    typedef union packed {
        rv_r_t r;
        rv_i_t i;
    } rv_inst_u;

endpackage

`default_nettype wire
